// File: all.f
+incdir+include
src/fetch_pkg.sv
src/pc_select.sv
src/btb_predictor.sv
src/fetch_line_buffer.sv
src/byte_rotator.sv
src/fetch_top.sv
testbench/fetch_tb.sv

// File: include/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Address width in bits
`define FETCH_XLEN 32

// Cache line and instruction window sizes in bytes
`define FETCH_LINE_BYTES 64
`define FETCH_WINDOW_BYTES 16

// Direct-mapped BTB depth
`define FETCH_BTB_ENTRIES 16

// Derived field widths of the fetch address
`define FETCH_OFFSET_W $clog2(`FETCH_LINE_BYTES)
`define FETCH_INDEX_W $clog2(`FETCH_BTB_ENTRIES)
`define FETCH_TAG_W (`FETCH_XLEN - `FETCH_INDEX_W - `FETCH_OFFSET_W)

// Flat bit widths of a line and a window
`define FETCH_LINE_W (`FETCH_LINE_BYTES * 8)
`define FETCH_WINDOW_W (`FETCH_WINDOW_BYTES * 8)

// Two-bit counter value written on allocation
`define FETCH_CTR_INIT 2'd2

`endif

// File: run.sh
#!/bin/sh
# Build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module fetch_tb \
    --Mdir obj_dir -o fetch_sim > build.log 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: src/btb_predictor.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module btb_predictor (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::fetch_addr_u lookup_pc,
    input  fetch_pkg::btb_update_t update,
    output fetch_pkg::prediction_t prediction
);

    // Payload of one BTB way
    typedef struct packed {
        logic [`FETCH_TAG_W-1:0] tag;
        logic [`FETCH_XLEN-1:0]  target;
        logic [1:0]              ctr;    // Two-bit saturating counter
    } btb_entry_t;

    btb_entry_t                    entries [`FETCH_BTB_ENTRIES];
    logic [`FETCH_BTB_ENTRIES-1:0] entry_valid;

    logic [`FETCH_INDEX_W-1:0] lk_idx;
    btb_entry_t                lk_entry;
    logic                      lk_hit;
    logic                      lk_taken;

    logic [`FETCH_INDEX_W-1:0] up_idx;
    btb_entry_t                up_entry;
    logic                      up_hit;
    logic [1:0]                up_ctr;

    // Same-cycle lookup
    assign lk_idx   = lookup_pc.f.index;
    assign lk_entry = entries[lk_idx];
    assign lk_hit   = entry_valid[lk_idx] && (lk_entry.tag == lookup_pc.f.tag);
    assign lk_taken = lk_hit && lk_entry.ctr[1];               // Counter 2 or 3

    assign prediction.taken  = lk_taken;
    assign prediction.target = lk_taken ? lk_entry.target : '0;

    // Resolve side
    assign up_idx   = update.pc.f.index;
    assign up_entry = entries[up_idx];
    assign up_hit   = entry_valid[up_idx] && (up_entry.tag == update.pc.f.tag);

    always_comb begin
        up_ctr = up_entry.ctr;
        if (update.taken) begin
            if (up_entry.ctr != 2'd3) begin
                up_ctr = up_entry.ctr + 2'd1;                   // Saturate up
            end
        end else begin
            if (up_entry.ctr != 2'd0) begin
                up_ctr = up_entry.ctr - 2'd1;                   // Saturate down
            end
        end
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;                                  // Empty BTB
        end else if (update.valid && !up_hit && update.taken) begin
            entry_valid[up_idx] <= 1'b1;                        // New allocation
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (update.valid) begin
            if (up_hit) begin
                entries[up_idx].ctr <= up_ctr;
                if (update.taken) begin
                    entries[up_idx].target <= update.target;    // Latest taken target
                end
            end else if (update.taken) begin
                entries[up_idx].tag    <= update.pc.f.tag;      // Replace whatever was here
                entries[up_idx].target <= update.target;
                entries[up_idx].ctr    <= `FETCH_CTR_INIT;      // Weakly taken
            end
            // Not-taken miss leaves the set alone
        end
    end

endmodule

// File: src/byte_rotator.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module byte_rotator (
    input  logic                     buf_valid,
    input  fetch_pkg::fetch_addr_u   buf_pc,
    input  logic [`FETCH_LINE_W-1:0] buf_line,
    output fetch_pkg::fetch_window_t window
);

    logic [`FETCH_LINE_BYTES-1:0][7:0] line_bytes;

    assign line_bytes = buf_line;                               // Byte 0 in bits 7:0

    // Window byte i is line byte (offset + i) mod line size
    always_comb begin
        logic [`FETCH_OFFSET_W-1:0] src;
        window.valid = buf_valid;
        window.pc    = buf_pc;
        for (int i = 0; i < `FETCH_WINDOW_BYTES; i++) begin
            src = buf_pc.f.offset + i[`FETCH_OFFSET_W-1:0];    // Wraps at line end
            window.bytes[i] = line_bytes[src];
        end
    end

endmodule

// File: src/fetch_line_buffer.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_line_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      resteer,
    input  logic                      line_hit,
    input  fetch_pkg::fetch_addr_u    fetch_pc,
    input  logic [`FETCH_LINE_W-1:0]  line_data,
    output logic                      buf_valid,
    output fetch_pkg::fetch_addr_u    buf_pc,
    output logic [`FETCH_LINE_W-1:0]  buf_line
);

    logic load;   // Capture this cycle's line
    logic hold;   // Freeze contents

    // Line answers the current fetch pc
    assign load = line_hit && !stall && !resteer;

    // Stall keeps the window, unless a resteer kills it
    assign hold = stall && !resteer;

    // Valid flag
    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (load) begin
            buf_valid <= 1'b1;
        end else if (hold) begin
            buf_valid <= buf_valid;
        end else begin
            buf_valid <= 1'b0;                                  // Miss or wrong path
        end
    end

    // Line and its address
    always_ff @(posedge clk) begin
        if (load) begin
            buf_pc   <= fetch_pc;                               // Keep unaligned offset
            buf_line <= line_data;
        end
    end

endmodule

// File: src/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    // Address split as the cache and BTB see it
    typedef struct packed {
        logic [`FETCH_TAG_W-1:0]    tag;
        logic [`FETCH_INDEX_W-1:0]  index;   // BTB set just above the offset
        logic [`FETCH_OFFSET_W-1:0] offset;  // Byte within the line
    } fetch_addr_fields_t;

    // One address word read flat or by field
    typedef union packed {
        logic [`FETCH_XLEN-1:0] flat;
        fetch_addr_fields_t     f;
    } fetch_addr_u;

    // Resteer source from rob, d1 or ras
    typedef struct packed {
        logic                   taken;
        logic [`FETCH_XLEN-1:0] target;
    } redirect_t;

    // BTB lookup result that also resteers the stage
    typedef struct packed {
        logic                   taken;
        logic [`FETCH_XLEN-1:0] target;
    } prediction_t;

    // Branch resolution from the back end
    typedef struct packed {
        logic                   valid;   // One-cycle strobe
        fetch_addr_u            pc;
        logic [`FETCH_XLEN-1:0] target;
        logic                   taken;
    } btb_update_t;

    // Instruction window handed to decode
    typedef struct packed {
        logic                                  valid;
        fetch_addr_u                           pc;
        logic [`FETCH_WINDOW_BYTES-1:0][7:0]   bytes;  // Byte 0 sits at pc
    } fetch_window_t;

endpackage

// File: src/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      line_hit,
    input  logic [`FETCH_LINE_W-1:0]  line_data,
    input  logic                      resteer,
    input  fetch_pkg::redirect_t      rob_redirect,
    input  fetch_pkg::redirect_t      d1_redirect,
    input  fetch_pkg::redirect_t      ras_redirect,
    input  fetch_pkg::btb_update_t    btb_update,
    output fetch_pkg::fetch_addr_u    pc_out,
    output fetch_pkg::prediction_t    br_prediction,
    output fetch_pkg::fetch_window_t  window
);

    logic                     buf_valid;
    fetch_pkg::fetch_addr_u   buf_pc;
    logic [`FETCH_LINE_W-1:0] buf_line;

    // Fetch PC and next-address priority
    pc_select pc_select_i (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .line_hit     (line_hit),
        .resteer      (resteer),
        .rob_redirect (rob_redirect),
        .d1_redirect  (d1_redirect),
        .ras_redirect (ras_redirect),
        .prediction   (br_prediction),   // Own resteer feeds back
        .pc           (pc_out)
    );

    // Looks up the pc being fetched
    btb_predictor btb_predictor_i (
        .clk        (clk),
        .rst        (rst),
        .lookup_pc  (pc_out),
        .update     (btb_update),
        .prediction (br_prediction)
    );

    // Captures the line the cache returns for this cycle's pc_out
    fetch_line_buffer fetch_line_buffer_i (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .resteer   (resteer),
        .line_hit  (line_hit),
        .fetch_pc  (pc_out),
        .line_data (line_data),
        .buf_valid (buf_valid),
        .buf_pc    (buf_pc),
        .buf_line  (buf_line)
    );

    // Align to fetch address and cut the window
    byte_rotator byte_rotator_i (
        .buf_valid (buf_valid),
        .buf_pc    (buf_pc),
        .buf_line  (buf_line),
        .window    (window)
    );

endmodule

// File: src/pc_select.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module pc_select (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  line_hit,
    input  logic                  resteer,
    input  fetch_pkg::redirect_t  rob_redirect,
    input  fetch_pkg::redirect_t  d1_redirect,
    input  fetch_pkg::redirect_t  ras_redirect,
    input  fetch_pkg::prediction_t prediction,
    output fetch_pkg::fetch_addr_u pc
);

    fetch_pkg::fetch_addr_u seq_pc;   // Start of the following line
    fetch_pkg::fetch_addr_u next_pc;
    logic                   redirect_any;

    // A resteer only counts if some source is taken
    assign redirect_any = resteer &&
                          (rob_redirect.taken || d1_redirect.taken || ras_redirect.taken);

    always_comb begin
        seq_pc          = pc;
        seq_pc.f.offset = '0;                                   // Realign first
        seq_pc.flat     = seq_pc.flat + `FETCH_LINE_BYTES;
    end

    // Next fetch address, highest priority first
    always_comb begin
        next_pc = pc;                                           // Default hold
        if (stall) begin
            next_pc = pc;
        end else if (redirect_any) begin
            if (rob_redirect.taken) begin                       // Oldest source wins
                next_pc.flat = rob_redirect.target;
            end else if (d1_redirect.taken) begin
                next_pc.flat = d1_redirect.target;
            end else begin
                next_pc.flat = ras_redirect.target;
            end
        end else if (prediction.taken) begin
            next_pc.flat = prediction.target;                   // BTB says taken
        end else if (line_hit) begin
            next_pc = seq_pc;
        end else begin
            next_pc = pc;                                       // Miss retries the same line
        end
    end

    // Fetch PC register
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

// File: testbench/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_tb;

    localparam int RST_CYCLES  = 5;
    localparam int RST_TIMEOUT = 50;        // Cycles allowed for reset release
    localparam int GAP_ROWS    = 8;         // Random hit or miss rows

    localparam fetch_pkg::redirect_t   NO_RD  = '0;
    localparam fetch_pkg::btb_update_t NO_UPD = '0;
    localparam fetch_pkg::prediction_t NT     = '0;    // Not taken

    // One table row
    typedef struct packed {
        logic [2:0]             ctl;        // {stall, hit, resteer}
        fetch_pkg::redirect_t   rob;
        fetch_pkg::redirect_t   d1;
        fetch_pkg::redirect_t   ras;
        fetch_pkg::btb_update_t upd;
        fetch_pkg::fetch_addr_u exp_pc;     // pc_out after the edge
        logic                   exp_valid;  // Window valid after the edge
        fetch_pkg::prediction_t exp_pred;   // Lookup of the new pc_out
    } row_t;

    logic                     clk;
    logic                     rst;
    logic                     stall;
    logic                     line_hit;
    logic [`FETCH_LINE_W-1:0] line_data;
    logic                     resteer;
    fetch_pkg::redirect_t     rob_redirect;
    fetch_pkg::redirect_t     d1_redirect;
    fetch_pkg::redirect_t     ras_redirect;
    fetch_pkg::btb_update_t   btb_update;
    fetch_pkg::fetch_addr_u   pc_out;
    fetch_pkg::prediction_t   br_prediction;
    fetch_pkg::fetch_window_t window;

    row_t        rows[$];
    string       row_names[$];
    logic [31:0] table_pc;                  // Running expected pc while building
    integer      seed = 32'h81dd_dc1b;
    int          pc_errors;
    int          pred_errors;
    int          win_errors;

    fetch_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .line_hit      (line_hit),
        .line_data     (line_data),
        .resteer       (resteer),
        .rob_redirect  (rob_redirect),
        .d1_redirect   (d1_redirect),
        .ras_redirect  (ras_redirect),
        .btb_update    (btb_update),
        .pc_out        (pc_out),
        .br_prediction (br_prediction),
        .window        (window)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

    // Byte k of a line is the low byte of line number * 7 + k
    function automatic logic [7:0] line_byte(input logic [31:0] addr, input logic [31:0] k);
        logic [31:0] v;
        v = (addr / `FETCH_LINE_BYTES) * 7 + k;
        return v[7:0];
    endfunction

    // Cache answers pc_out in the same cycle
    always_comb begin
        for (int k = 0; k < `FETCH_LINE_BYTES; k++) begin
            line_data[k*8 +: 8] = line_byte(pc_out.flat, k);
        end
    end

    // Expected window for a fetch at pc
    function automatic fetch_pkg::fetch_window_t build_window(input logic [31:0] pc);
        fetch_pkg::fetch_window_t w;
        logic [31:0]              idx;
        w.valid   = 1'b1;
        w.pc.flat = pc;
        for (int i = 0; i < `FETCH_WINDOW_BYTES; i++) begin
            idx        = (pc + i) % `FETCH_LINE_BYTES;      // Wraps inside the line
            w.bytes[i] = line_byte(pc, idx);
        end
        return w;
    endfunction

    function automatic fetch_pkg::redirect_t rd(input logic [31:0] target);
        fetch_pkg::redirect_t r;
        r.taken  = 1'b1;
        r.target = target;
        return r;
    endfunction

    function automatic fetch_pkg::prediction_t pt(input logic [31:0] target);
        fetch_pkg::prediction_t p;
        p.taken  = 1'b1;
        p.target = target;
        return p;
    endfunction

    function automatic fetch_pkg::btb_update_t upd_of(input logic [31:0] pc,
                                                       input logic [31:0] target,
                                                       input logic taken);
        fetch_pkg::btb_update_t u;
        u.valid   = 1'b1;
        u.pc.flat = pc;
        u.target  = target;
        u.taken   = taken;
        return u;
    endfunction

    task automatic add_row(input string name, input logic [2:0] ctl,
                           input fetch_pkg::redirect_t rob, input fetch_pkg::redirect_t d1,
                           input fetch_pkg::redirect_t ras, input fetch_pkg::btb_update_t upd,
                           input logic [31:0] exp_pc, input logic exp_valid,
                           input fetch_pkg::prediction_t exp_pred);
        row_t r;
        r.ctl         = ctl;
        r.rob         = rob;
        r.d1          = d1;
        r.ras         = ras;
        r.upd         = upd;
        r.exp_pc.flat = exp_pc;
        r.exp_valid   = exp_valid;
        r.exp_pred    = exp_pred;
        rows.push_back(r);
        row_names.push_back(name);
        table_pc = exp_pc;
    endtask

    // Random gaps where a hit steps one line and a miss holds
    task automatic add_gap_rows(input int count);
        integer      r;
        logic [31:0] next_pc;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            if (r[0]) begin
                next_pc = (table_pc / `FETCH_LINE_BYTES + 1) * `FETCH_LINE_BYTES;
            end else begin
                next_pc = table_pc;
            end
            add_row($sformatf("gap%0d", i), {1'b0, r[0], 1'b0}, NO_RD, NO_RD, NO_RD, NO_UPD,
                    next_pc, r[0], NT);
        end
    endtask

    task automatic build_table();
        table_pc = 32'h0;
        add_row("seq0", 3'b010, NO_RD, NO_RD, NO_RD, NO_UPD, 32'h0040, 1'b1, NT);
        add_row("seq1", 3'b010, NO_RD, NO_RD, NO_RD, NO_UPD, 32'h0080, 1'b1, NT);
        add_row("seq2", 3'b010, NO_RD, NO_RD, NO_RD, NO_UPD, 32'h00c0, 1'b1, NT);
        // Resteer priority rob over d1 over ras
        add_row("rs_all", 3'b011, rd(32'h1000), rd(32'h2000), rd(32'h3000), NO_UPD,
                32'h1000, 1'b0, NT);
        add_row("rs_d1", 3'b011, NO_RD, rd(32'h2000), rd(32'h3000), NO_UPD,
                32'h2000, 1'b0, NT);
        add_row("rs_ras", 3'b011, NO_RD, NO_RD, rd(32'h3038), NO_UPD, 32'h3038, 1'b0, NT);
        add_row("wrap", 3'b010, NO_RD, NO_RD, NO_RD, NO_UPD, 32'h3040, 1'b1, NT);
        add_row("wrap_next", 3'b010, NO_RD, NO_RD, NO_RD, NO_UPD, 32'h3080, 1'b1, NT);
        add_row("stall_hit", 3'b110, NO_RD, NO_RD, NO_RD, NO_UPD, 32'h3080, 1'b1, NT);
        add_row("stall_miss", 3'b100, NO_RD, NO_RD, NO_RD, NO_UPD, 32'h3080, 1'b1, NT);
        add_row("rs_none", 3'b011, NO_RD, NO_RD, NO_RD, NO_UPD, 32'h30c0, 1'b0, NT);
        add_row("seq3", 3'b010, NO_RD, NO_RD, NO_RD, NO_UPD, 32'h3100, 1'b1, NT);
        add_gap_rows(GAP_ROWS);
        // Train 0x4000 to 0x5010, then retarget to 0x5020 with the counter at 3
        add_row("go_4000", 3'b011, rd(32'h4000), NO_RD, NO_RD, NO_UPD, 32'h4000, 1'b0, NT);
        add_row("train", 3'b000, NO_RD, NO_RD, NO_RD, upd_of(32'h4000, 32'h5010, 1'b1),
                32'h4000, 1'b0, pt(32'h5010));
        add_row("train2", 3'b100, NO_RD, NO_RD, NO_RD, upd_of(32'h4000, 32'h5020, 1'b1),
                32'h4000, 1'b0, pt(32'h5020));
        add_row("pred_take", 3'b010, NO_RD, NO_RD, NO_RD, NO_UPD, 32'h5020, 1'b1, NT);
        add_row("pred_next", 3'b010, NO_RD, NO_RD, NO_RD, NO_UPD, 32'h5040, 1'b1, NT);
        add_row("back_4000", 3'b011, rd(32'h4000), NO_RD, NO_RD, NO_UPD,
                32'h4000, 1'b0, pt(32'h5020));
        // Not-taken updates keep the stored target
        add_row("untrain1", 3'b100, NO_RD, NO_RD, NO_RD, upd_of(32'h4000, 32'h5010, 1'b0),
                32'h4000, 1'b0, pt(32'h5020));
        add_row("untrain2", 3'b100, NO_RD, NO_RD, NO_RD, upd_of(32'h4000, 32'h5010, 1'b0),
                32'h4000, 1'b0, NT);
        add_row("seq_4000", 3'b010, NO_RD, NO_RD, NO_RD, NO_UPD, 32'h4040, 1'b1, NT);
        // Not-taken miss must not allocate
        add_row("nt_miss", 3'b010, NO_RD, NO_RD, NO_RD, upd_of(32'h6080, 32'h7000, 1'b0),
                32'h4080, 1'b1, NT);
        add_row("go_6080", 3'b011, rd(32'h6080), NO_RD, NO_RD, NO_UPD, 32'h6080, 1'b0, NT);
        add_row("seq_6080", 3'b010, NO_RD, NO_RD, NO_RD, NO_UPD, 32'h60c0, 1'b1, NT);
    endtask

    task automatic drive_row(input row_t r);
        stall        = r.ctl[2];
        line_hit     = r.ctl[1];
        resteer      = r.ctl[0];
        rob_redirect = r.rob;
        d1_redirect  = r.d1;
        ras_redirect = r.ras;
        btb_update   = r.upd;
    endtask

    task automatic check_pc(input string name, input fetch_pkg::fetch_addr_u exp,
                            input fetch_pkg::fetch_addr_u act);
        if (act !== exp) begin
            pc_errors++;
            $display("Fail %s: pc expected %h, actual %h", name, exp.flat, act.flat);
        end
    endtask

    task automatic check_prediction(input string name, input fetch_pkg::prediction_t exp,
                                    input fetch_pkg::prediction_t act);
        if (act !== exp) begin
            pred_errors++;
            $display("Fail %s: prediction expected %h, actual %h", name, exp, act);
        end
    endtask

    // Invalid windows are compared on valid only
    task automatic check_window(input string name, input fetch_pkg::fetch_window_t exp,
                                input fetch_pkg::fetch_window_t act);
        if (exp.valid && act !== exp) begin
            win_errors++;
            $display("Fail %s: window expected %h, actual %h", name, exp, act);
        end else if (!exp.valid && act.valid !== 1'b0) begin
            win_errors++;
            $display("Fail %s: window valid expected 0, actual %b", name, act.valid);
        end
    endtask

    task automatic run_table();
        fetch_pkg::fetch_window_t exp_win;
        fetch_pkg::fetch_addr_u   reset_pc;
        logic [31:0]              cur_pc;   // pc_out during the row's cycle
        exp_win  = '0;
        reset_pc = '0;
        cur_pc   = 32'h0;
        check_pc("reset", reset_pc, pc_out);
        check_prediction("reset", NT, br_prediction);
        check_window("reset", exp_win, window);
        for (int n = 0; n < rows.size(); n++) begin
            drive_row(rows[n]);
            @(posedge clk);
            #1;
            if (rows[n].exp_valid && !rows[n].ctl[2]) begin
                exp_win = build_window(cur_pc);             // Freshly loaded line
            end
            exp_win.valid = rows[n].exp_valid;              // Stall keeps old bytes
            check_pc(row_names[n], rows[n].exp_pc, pc_out);
            check_prediction(row_names[n], rows[n].exp_pred, br_prediction);
            check_window(row_names[n], exp_win, window);
            cur_pc = rows[n].exp_pc.flat;
        end
        drive_row('0);
    endtask

    initial begin
        int   waited;
        logic released;
        pc_errors   = 0;
        pred_errors = 0;
        win_errors  = 0;
        drive_row('0);                                      // All inputs idle
        build_table();
        waited   = 0;
        released = 1'b0;
        while (!released && waited < RST_TIMEOUT) begin
            @(posedge clk);
            waited++;
            if (rst === 1'b0) begin
                released = 1'b1;
            end
        end
        if (!released) begin
            $display("Timeout: reset was not released within %0d cycles", RST_TIMEOUT);
            $display("Done: errors found");
        end else begin
            #1;
            run_table();
            $display("Errors: pc %0d, prediction %0d, window %0d",
                     pc_errors, pred_errors, win_errors);
            if (pc_errors + pred_errors + win_errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
        end
        $finish;
    end

endmodule
